// File: timer_pkg.sv
`default_nettype none

package timer_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Timer FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        IDLE     = 3'b000,
        RUNNING  = 3'b001,
        ONE_SHOT = 3'b010,
        PERIODIC = 3'b011,
        PWM      = 3'b100,
        PWM_RUN  = 3'b101,
        OFF      = 3'b110
    } state_t;

    localparam int COUNT_W = 32;   // Counter and load value width

    // Register map
    localparam logic [1:0] ADDR_CTRL   = 2'd0;
    localparam logic [1:0] ADDR_LOAD   = 2'd1;
    localparam logic [1:0] ADDR_STATUS = 2'd2;
    localparam logic [1:0] ADDR_COUNT  = 2'd3;   // Read only

    // Mode codes
    localparam logic [1:0] MODE_NONE     = 2'd0;
    localparam logic [1:0] MODE_ONE_SHOT = 2'd1;
    localparam logic [1:0] MODE_PERIODIC = 2'd2;
    localparam logic [1:0] MODE_PWM      = 2'd3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field positions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CTRL_START_BIT  = 0;   // Self clearing
    localparam int CTRL_MODE_LSB   = 1;   // Two bits wide
    localparam int CTRL_OFF_BIT    = 3;
    localparam int CTRL_IRQ_EN_BIT = 4;

    localparam int STAT_IRQ_BIT = 0;   // Write 1 to clear
    localparam int STAT_CNT_LSB = 16;
    localparam int STAT_CNT_W   = 16;  // Timeout counter wraps at this width

endpackage

`default_nettype wire

// File: timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module timer_regs import timer_pkg::*; (
    input  logic                  prescaled_clk,
    input  logic                  reset_n,
    input  logic                  wr_en,
    input  logic [1:0]            addr,
    input  logic [31:0]           wdata,
    input  logic [COUNT_W-1:0]    current_count,
    input  logic                  irq_status,
    input  logic [STAT_CNT_W-1:0] timeout_count,

    output logic [31:0]           rdata,
    output logic [COUNT_W-1:0]    load_value,
    output logic [1:0]            mode,
    output logic                  start,
    output logic                  pwm_mode,
    output logic                  off_signal,
    output logic                  irq_en,
    output logic                  irq_clear
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            load_value <= '0;
            mode       <= MODE_NONE;
            off_signal <= 1'b0;
            irq_en     <= 1'b0;
            start      <= 1'b0;
            irq_clear  <= 1'b0;
        end else begin
            // Pulses last one cycle unless rewritten
            start     <= 1'b0;
            irq_clear <= 1'b0;
            if (wr_en) begin
                case (addr)
                    ADDR_CTRL: begin
                        mode       <= wdata[CTRL_MODE_LSB +: 2];
                        off_signal <= wdata[CTRL_OFF_BIT];
                        irq_en     <= wdata[CTRL_IRQ_EN_BIT];
                        start      <= wdata[CTRL_START_BIT];
                    end
                    ADDR_LOAD: begin
                        load_value <= wdata[COUNT_W-1:0];
                    end
                    ADDR_STATUS: begin
                        irq_clear <= wdata[STAT_IRQ_BIT];
                    end
                    default: begin
                        // COUNT ignores writes
                    end
                endcase
            end
        end
    end

    assign pwm_mode = (mode == MODE_PWM);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Readback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rdata = '0;
        case (addr)
            ADDR_CTRL: begin
                rdata[CTRL_MODE_LSB +: 2] = mode;   // Start bit reads as 0
                rdata[CTRL_OFF_BIT]       = off_signal;
                rdata[CTRL_IRQ_EN_BIT]    = irq_en;
            end
            ADDR_LOAD: begin
                rdata[COUNT_W-1:0] = load_value;
            end
            ADDR_STATUS: begin
                rdata[STAT_IRQ_BIT]                 = irq_status;
                rdata[STAT_CNT_LSB +: STAT_CNT_W]   = timeout_count;
            end
            default: begin
                rdata[COUNT_W-1:0] = current_count;
            end
        endcase
    end

    // Software must space its strobes
    a_pulses_single: assert property (
        @(posedge prescaled_clk) disable iff (!reset_n)
        (start |=> !start) and (irq_clear |=> !irq_clear)
    );

endmodule

`default_nettype wire

// File: down_counter.sv
`timescale 1ns/1ps
`default_nettype none

module down_counter import timer_pkg::*; (
    input  logic               prescaled_clk,
    input  logic               reset_n,
    input  logic               enable,
    input  logic               reload_signal,
    input  logic               pwm_signal,
    input  logic [COUNT_W-1:0] load_value,
    input  logic [1:0]         mode,

    output logic [COUNT_W-1:0] current_count,
    output logic               one_shot,
    output logic               periodic
);

    logic count_zero;
    logic expired;

    assign count_zero = (current_count == '0);

    // Reload has priority over counting
    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            current_count <= '0;
        end else if (reload_signal || pwm_signal) begin
            current_count <= load_value;
        end else if (enable && !count_zero) begin
            current_count <= current_count - COUNT_W'(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expiry events, same cycle as zero
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign expired  = enable && count_zero;
    assign one_shot = expired && (mode == MODE_ONE_SHOT);
    assign periodic = expired && (mode == MODE_PERIODIC);

    // No underflow from zero unless a reload brings it in
    a_no_wrap: assert property (
        @(posedge prescaled_clk) disable iff (!reset_n)
        (count_zero && !reload_signal && !pwm_signal) |=> (current_count != '1)
    );

endmodule

`default_nettype wire

// File: counter_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module counter_fsm import timer_pkg::*; (
    input  logic               prescaled_clk,
    input  logic               reset_n,
    input  logic               start,
    input  logic               one_shot,
    input  logic               periodic,
    input  logic               pwm_mode,
    input  logic               off_signal,
    input  logic [COUNT_W-1:0] current_count,

    output logic               enable,
    output logic               reload_signal,
    output logic               pwm_signal,
    output logic               time_out,
    output logic               pwm_out
);

    state_t state;
    state_t next_state;

    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) next_state = RUNNING;
            end
            RUNNING: begin
                // Expiry first, then PWM, then off
                if (one_shot) begin
                    next_state = ONE_SHOT;
                end else if (periodic) begin
                    next_state = PERIODIC;
                end else if (pwm_mode) begin
                    next_state = PWM;
                end else if (off_signal) begin
                    next_state = OFF;
                end
            end
            ONE_SHOT: next_state = IDLE;
            PERIODIC: next_state = RUNNING;
            PWM:      next_state = PWM_RUN;
            PWM_RUN: begin
                if (current_count == '0) next_state = PERIODIC;   // End of high phase
            end
            OFF: begin
                if (!off_signal) next_state = RUNNING;
            end
            default: next_state = IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        enable        = 1'b0;
        reload_signal = 1'b0;
        pwm_signal    = 1'b0;
        time_out      = 1'b0;
        pwm_out       = 1'b0;
        case (state)
            IDLE:     reload_signal = 1'b1;   // Keep count at load value
            RUNNING:  enable = 1'b1;
            ONE_SHOT, PERIODIC: begin
                reload_signal = 1'b1;
                time_out      = 1'b1;
            end
            PWM:      pwm_signal = 1'b1;      // Load for the high phase
            PWM_RUN: begin
                enable  = 1'b1;
                pwm_out = 1'b1;
            end
            default: begin
                // OFF freezes the count
            end
        endcase
    end

    a_out_exclusive: assert property (
        @(posedge prescaled_clk) disable iff (!reset_n)
        !(time_out && pwm_out)
    );

    // A timeout always returns through RUNNING or IDLE
    a_timeout_single: assert property (
        @(posedge prescaled_clk) disable iff (!reset_n)
        time_out |=> !time_out
    );

endmodule

`default_nettype wire

// File: timer_output.sv
`timescale 1ns/1ps
`default_nettype none

module timer_output import timer_pkg::*; (
    input  logic                  prescaled_clk,
    input  logic                  reset_n,
    input  logic                  time_out,
    input  logic                  pwm_out,
    input  logic                  irq_en,
    input  logic                  irq_clear,

    output logic                  pwm_pin,
    output logic                  irq,
    output logic                  irq_status,
    output logic [STAT_CNT_W-1:0] timeout_count
);

    // Registered pin, glitch free for the pad
    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            pwm_pin <= 1'b0;
        end else begin
            pwm_pin <= pwm_out;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sticky interrupt
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_status <= 1'b0;
        end else if (time_out) begin
            irq_status <= 1'b1;   // Set beats clear
        end else if (irq_clear) begin
            irq_status <= 1'b0;
        end
    end

    assign irq = irq_status && irq_en;

    // Timeout events seen by software, wraps
    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            timeout_count <= '0;
        end else if (time_out) begin
            timeout_count <= timeout_count + STAT_CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module timer_top import timer_pkg::*; (
    input  logic        prescaled_clk,
    input  logic        reset_n,
    input  logic        wr_en,
    input  logic [1:0]  addr,
    input  logic [31:0] wdata,

    output logic [31:0] rdata,
    output logic        pwm_pin,
    output logic        irq
);

    // Register block controls
    logic [COUNT_W-1:0]    load_value;
    logic [1:0]            mode;
    logic                  start;
    logic                  pwm_mode;
    logic                  off_signal;
    logic                  irq_en;
    logic                  irq_clear;

    // Counter and FSM
    logic [COUNT_W-1:0]    current_count;
    logic                  one_shot;
    logic                  periodic;
    logic                  enable;
    logic                  reload_signal;
    logic                  pwm_signal;
    logic                  time_out;
    logic                  pwm_out;

    // Status back to software
    logic                  irq_status;
    logic [STAT_CNT_W-1:0] timeout_count;

    timer_regs u_timer_regs (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .wr_en         (wr_en),
        .addr          (addr),
        .wdata         (wdata),
        .current_count (current_count),
        .irq_status    (irq_status),
        .timeout_count (timeout_count),
        .rdata         (rdata),
        .load_value    (load_value),
        .mode          (mode),
        .start         (start),
        .pwm_mode      (pwm_mode),
        .off_signal    (off_signal),
        .irq_en        (irq_en),
        .irq_clear     (irq_clear)
    );

    down_counter u_down_counter (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .enable        (enable),
        .reload_signal (reload_signal),
        .pwm_signal    (pwm_signal),
        .load_value    (load_value),
        .mode          (mode),
        .current_count (current_count),
        .one_shot      (one_shot),
        .periodic      (periodic)
    );

    counter_fsm u_counter_fsm (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .start         (start),
        .one_shot      (one_shot),
        .periodic      (periodic),
        .pwm_mode      (pwm_mode),
        .off_signal    (off_signal),
        .current_count (current_count),
        .enable        (enable),
        .reload_signal (reload_signal),
        .pwm_signal    (pwm_signal),
        .time_out      (time_out),
        .pwm_out       (pwm_out)
    );

    timer_output u_timer_output (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .time_out      (time_out),
        .pwm_out       (pwm_out),
        .irq_en        (irq_en),
        .irq_clear     (irq_clear),
        .pwm_pin       (pwm_pin),
        .irq           (irq),
        .irq_status    (irq_status),
        .timeout_count (timeout_count)
    );

endmodule

`default_nettype wire

// File: tb_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_timer import timer_pkg::*; ();

    localparam int CLK_HALF = 4;   // 8 ns period

    logic        prescaled_clk = 1'b0;
    logic        reset_n;
    logic        wr_en;
    logic [1:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        pwm_pin;
    logic        irq;

    logic [7:0]  lfsr_state;
    int          cycle_count = 0;

    timer_top u_timer_top (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .wr_en         (wr_en),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .pwm_pin       (pwm_pin),
        .irq           (irq)
    );

    always #CLK_HALF prescaled_clk = ~prescaled_clk;

    always @(posedge prescaled_clk) begin
        cycle_count <= cycle_count + 1;   // Time stamps for period checks
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;   // x^8 + x^6 + x^5 + x^4 + 1
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [31:0] ctrl_word(input logic [1:0] mode, input logic off,
                                              input logic irq_en, input logic start);
        logic [31:0] word;
        word                      = '0;
        word[CTRL_MODE_LSB +: 2]  = mode;
        word[CTRL_OFF_BIT]        = off;
        word[CTRL_IRQ_EN_BIT]     = irq_en;
        word[CTRL_START_BIT]      = start;
        return word;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t %s: expected 0x%0h, got 0x%0h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic apply_reset();
        @(negedge prescaled_clk);
        reset_n = 1'b0;
        wr_en   = 1'b0;
        repeat (10) @(negedge prescaled_clk);
        reset_n = 1'b1;
    endtask

    task automatic reg_write(input logic [1:0] where, input logic [31:0] data);
        @(negedge prescaled_clk);
        wr_en = 1'b1;
        addr  = where;
        wdata = data;
        @(negedge prescaled_clk);
        wr_en = 1'b0;
    endtask

    // Combinational read, takes no clock
    task automatic reg_read(input logic [1:0] where, output logic [31:0] data);
        addr = where;
        #1;
        data = rdata;
    endtask

    task automatic clear_irq();
        reg_write(ADDR_STATUS, 32'd1 << STAT_IRQ_BIT);
        @(negedge prescaled_clk);
        check_value("irq after clear", 32'(irq), 32'd0);
    endtask

    task automatic wait_irq(input int limit, output int cycles);
        state_t fsm_state;
        cycles = 0;
        while (!irq && cycles < limit) begin
            @(negedge prescaled_clk);
            cycles++;
        end
        if (!irq) begin
            fsm_state = u_timer_top.u_counter_fsm.state;
            abort_run($sformatf("No irq within %0d cycles, FSM in %s", limit, fsm_state.name()));
        end
    endtask

    task automatic wait_pwm_rise(input int limit);
        logic prev;
        logic rose;
        int   cycles;
        prev   = pwm_pin;
        rose   = 1'b0;
        cycles = 0;
        while (!rose && cycles < limit) begin
            @(negedge prescaled_clk);
            cycles++;
            rose = pwm_pin && !prev;
            prev = pwm_pin;
        end
        if (!rose) begin
            abort_run($sformatf("pwm_pin did not rise within %0d cycles", limit));
        end
    endtask

    // Starts on the sample where pwm_pin has just risen
    task automatic measure_pwm_period(input int limit, output int high, output int period);
        logic prev;
        logic rose;
        prev   = pwm_pin;
        rose   = 1'b0;
        high   = 0;
        period = 0;
        while (!rose && period < limit) begin
            high = high + (pwm_pin ? 1 : 0);
            @(negedge prescaled_clk);
            period++;
            rose = pwm_pin && !prev;
            prev = pwm_pin;
        end
        if (!rose) begin
            abort_run($sformatf("PWM period did not end within %0d cycles", limit));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_readback();
        logic [31:0] value;
        logic [31:0] pattern;
        int          load;
        apply_reset();
        reg_read(ADDR_COUNT, value);
        check_value("COUNT after reset", value, 32'd0);
        check_value("irq after reset", 32'(irq), 32'd0);
        check_value("pwm_pin after reset", 32'(pwm_pin), 32'd0);
        random_bits(32, pattern);
        reg_write(ADDR_LOAD, pattern);
        reg_read(ADDR_LOAD, value);
        check_value("LOAD readback", value, pattern);
        load = 6;
        reg_write(ADDR_LOAD, 32'(load));
        reg_write(ADDR_CTRL, ctrl_word(MODE_NONE, 1'b0, 1'b1, 1'b1));
        repeat (load + 2) @(negedge prescaled_clk);
        reg_read(ADDR_COUNT, value);
        check_value("COUNT after countdown", value, 32'd0);
        repeat (2 * load) begin
            @(negedge prescaled_clk);
            check_value("irq in mode none", 32'(irq), 32'd0);
        end
        reg_read(ADDR_COUNT, value);
        check_value("COUNT holds at zero", value, 32'd0);
    endtask

    task automatic test_one_shot();
        logic [31:0] value;
        int          load;
        int          cycles;
        load = 10;
        apply_reset();
        reg_write(ADDR_LOAD, 32'(load));
        reg_write(ADDR_CTRL, ctrl_word(MODE_ONE_SHOT, 1'b0, 1'b1, 1'b1));
        wait_irq(load + 8, cycles);
        check_value("one-shot irq latency in window",
                    32'(cycles >= load + 1 && cycles <= load + 3), 32'd1);
        reg_read(ADDR_STATUS, value);
        check_value("STATUS irq bit", 32'(value[STAT_IRQ_BIT]), 32'd1);
        check_value("timeout count", 32'(value[STAT_CNT_LSB +: STAT_CNT_W]), 32'd1);
        reg_read(ADDR_COUNT, value);
        check_value("COUNT reloaded", value, 32'(load));
        clear_irq();
        repeat (3 * load) begin
            @(negedge prescaled_clk);
            check_value("irq after one-shot", 32'(irq), 32'd0);
        end
    endtask

    task automatic test_periodic();
        logic [31:0] bits;
        logic [31:0] value;
        int          load;
        int          cycles;
        int          last_rise;
        random_bits(4, bits);
        load = int'(bits) + 2;
        apply_reset();
        reg_write(ADDR_LOAD, 32'(load));
        reg_write(ADDR_CTRL, ctrl_word(MODE_PERIODIC, 1'b0, 1'b1, 1'b1));
        wait_irq(load + 8, cycles);
        last_rise = cycle_count;
        reg_read(ADDR_STATUS, value);
        check_value("timeout count", 32'(value[STAT_CNT_LSB +: STAT_CNT_W]), 32'd1);
        for (int n = 2; n <= 5; n++) begin
            clear_irq();
            wait_irq(2 * load + 8, cycles);
            check_value("periodic irq spacing", 32'(cycle_count - last_rise), 32'(load + 2));
            last_rise = cycle_count;
            reg_read(ADDR_STATUS, value);
            check_value("timeout count", 32'(value[STAT_CNT_LSB +: STAT_CNT_W]), 32'(n));
        end
    endtask

    task automatic test_pwm();
        logic [31:0] bits;
        int          load;
        int          high;
        int          period;
        random_bits(3, bits);
        load = int'(bits) + 3;
        apply_reset();
        reg_write(ADDR_LOAD, 32'(load));
        reg_write(ADDR_CTRL, ctrl_word(MODE_PWM, 1'b0, 1'b0, 1'b1));
        wait_pwm_rise(load + 10);
        repeat (3) begin
            measure_pwm_period(2 * load + 10, high, period);
            check_value("PWM high cycles", 32'(high), 32'(load + 1));
            check_value("PWM period", 32'(period), 32'(load + 4));
        end
    endtask

    task automatic test_off();
        logic [31:0] first;
        logic [31:0] second;
        int          load;
        int          cycles;
        load = 12;
        apply_reset();
        reg_write(ADDR_LOAD, 32'(load));
        reg_write(ADDR_CTRL, ctrl_word(MODE_PERIODIC, 1'b0, 1'b1, 1'b1));
        wait_irq(load + 8, cycles);
        clear_irq();
        reg_write(ADDR_CTRL, ctrl_word(MODE_PERIODIC, 1'b1, 1'b1, 1'b0));
        repeat (3) @(negedge prescaled_clk);
        reg_read(ADDR_COUNT, first);
        repeat (5) begin
            @(negedge prescaled_clk);
            check_value("irq while off", 32'(irq), 32'd0);
        end
        reg_read(ADDR_COUNT, second);
        check_value("COUNT frozen while off", second, first);
        reg_write(ADDR_CTRL, ctrl_word(MODE_PERIODIC, 1'b0, 1'b1, 1'b0));
        wait_irq(load + 3, cycles);   // Resumes from the frozen count
    endtask

    initial begin
        reset_n    = 1'b0;
        wr_en      = 1'b0;
        addr       = ADDR_CTRL;
        wdata      = '0;
        lfsr_state = 8'd35;
        test_reset_readback();
        test_one_shot();
        test_periodic();
        test_pwm();
        test_off();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: timer.f
timer_pkg.sv
timer_regs.sv
down_counter.sv
counter_fsm.sv
timer_output.sv
timer_top.sv
tb_timer.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_timer
FILELIST = timer.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
